/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pcs_rx_decoder
SEED      ?= 1
OBJ_DIR   ?= obj_dir
FLIST     ?= compile.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+testbench
verilog/pcs_dec_pkg.sv
verilog/decode_bus_if.sv
verilog/rx_descrambler.sv
verilog/block_classifier.sv
verilog/lane_decoder.sv
verilog/decoded_output_stage.sv
verilog/pcs_rx_decoder.sv
testbench/tb_pcs_rx_decoder.sv

/* testbench/tb_pcs_model.svh */
`ifndef TB_PCS_MODEL_SVH
`define TB_PCS_MODEL_SVH

logic [57:0] tx_scr;  // Bit 0 is the newest transmitted bit

// Bit 8 set for a legal seven-bit code
function automatic logic [8:0] map_code(input logic [6:0] code);
   case (code)
      7'h00:   return {1'b1, 8'h07};
      7'h06:   return {1'b1, 8'h06};
      7'h1e:   return {1'b1, 8'hfe};
      7'h2d:   return {1'b1, 8'h1c};
      7'h33:   return {1'b1, 8'h3c};
      7'h4b:   return {1'b1, 8'h7c};
      7'h55:   return {1'b1, 8'hbc};
      7'h66:   return {1'b1, 8'hdc};
      7'h78:   return {1'b1, 8'hf7};
      default: return {1'b0, 8'hfe};
   endcase
endfunction

// Block kind 0 data, 1 all control, 2 start in lane 0, 3 start in lane 4, 4+t terminate in t
function automatic logic [7:0] type_of_kind(input int kind);
   case (kind)
      1:       return 8'h1e;
      2:       return 8'h78;
      3:       return 8'h33;
      4:       return 8'h87;
      5:       return 8'h99;
      6:       return 8'haa;
      7:       return 8'hb4;
      8:       return 8'hcc;
      9:       return 8'hd2;
      10:      return 8'he1;
      default: return 8'hff;
   endcase
endfunction

function automatic bit type_known(input logic [7:0] block_type);
   for (int kind = 1; kind < 12; kind++)
      if (type_of_kind(kind) == block_type)
         return 1'b1;
   return 1'b0;
endfunction

task automatic scramble_payload(input logic [63:0] pl, output logic [63:0] tx);
   logic b;
   for (int i = 0; i < 64; i++)
   begin
      b      = pl[i] ^ tx_scr[38] ^ tx_scr[57];
      tx[i]  = b;
      tx_scr = {tx_scr[56:0], b};
   end
endtask

task automatic build_block(input int kind, output logic [63:0] pl, output logic [1:0] sync,
                           output logic [63:0] exp_d, output logic [7:0] exp_c);
   logic [8:0] m;
   int         lk [8];  // 0 byte k, 1 byte k+1, 2 code, 3 start, 4 terminate
   pl   = {$urandom, $urandom};
   sync = (kind == 0) ? 2'b10 : 2'b01;
   for (int k = 0; k < 8; k++)
   begin
      case (kind)
         0:       lk[k] = 0;
         1:       lk[k] = 2;
         2:       lk[k] = (k == 0) ? 3 : 0;
         3:       lk[k] = (k < 4) ? 2 : ((k == 4) ? 3 : 0);
         default: lk[k] = (k < kind - 4) ? 1 : ((k == kind - 4) ? 4 : 2);
      endcase
   end
   if (kind != 0)
      pl[7:0] = type_of_kind(kind);
   for (int k = 0; k < 8; k++)
   begin
      if (lk[k] == 2)
      begin
         do
         begin
            pl[8 + 7 * k +: 7] = 7'($urandom);
            m = map_code(pl[8 + 7 * k +: 7]);
         end
         while (!m[8]);
      end
   end
   for (int k = 0; k < 8; k++)
   begin
      m = map_code(pl[8 + 7 * k +: 7]);
      case (lk[k])
         0:       exp_d[8 * k +: 8] = pl[8 * k +: 8];
         1:       exp_d[8 * k +: 8] = pl[8 * k + 8 +: 8];
         2:       exp_d[8 * k +: 8] = m[7:0];
         3:       exp_d[8 * k +: 8] = 8'hfb;
         default: exp_d[8 * k +: 8] = 8'hfd;
      endcase
      exp_c[k] = (lk[k] > 1);
   end
endtask

`endif

/* testbench/tb_pcs_rx_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pcs_rx_decoder;

   localparam int CLK_PERIOD = 40;
   localparam int N_DATA     = 200;
   localparam int N_CTRL     = 100;
   localparam int N_MIXED    = 300;
   localparam int N_BAD      = 90;
   localparam int N_GAPPED   = 200;
   // At most one idle cycle per block in the gapped test
   localparam int RUN_CYCLES = 4 + N_DATA + N_CTRL + N_MIXED + N_BAD + 2 * N_GAPPED;

   logic        CLK;
   logic        reset;
   logic [65:0] block_in;
   logic        block_valid;
   logic        out_valid;
   logic [63:0] xgmii_data;
   logic [7:0]  xgmii_ctrl;

   logic [71:0] exp_q [$];
   logic [71:0] exp_word;
   logic [71:0] held_word;
   logic        exp_valid;
   logic        expect_cleared;
   int          pass_count;
   int          fail_count;

   `include "tb_pcs_model.svh"

   pcs_rx_decoder dut_i
   (
      .CLK         (CLK),
      .reset       (reset),
      .block_in    (block_in),
      .block_valid (block_valid),
      .out_valid   (out_valid),
      .xgmii_data  (xgmii_data),
      .xgmii_ctrl  (xgmii_ctrl)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   initial
   begin
      #((RUN_CYCLES + 100) * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", RUN_CYCLES + 100);
      $display("TEST FAILED");
      $finish;
   end

   always @(posedge CLK)
      exp_valid <= reset ? 1'b0 : block_valid;  // One cycle latency

   always @(negedge CLK)
   begin
      if (!reset)
      begin
         if (out_valid !== exp_valid)
         begin
            $display("ERROR out_valid: expected %h, got %h at %0t", exp_valid, out_valid, $time);
            fail_count++;
         end
         else
            pass_count++;
         if (expect_cleared)
         begin
            if (xgmii_data !== 64'h0 || xgmii_ctrl !== 8'h00)
            begin
               $display("ERROR xgmii_data/xgmii_ctrl: expected 0/00, got %h/%h",
                        xgmii_data, xgmii_ctrl);
               fail_count++;
            end
            else
               pass_count++;
         end
         if (out_valid === 1'b1)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Output word at %0t with no block outstanding", $time);
               fail_count++;
            end
            else
            begin
               exp_word  = exp_q.pop_front();
               held_word = exp_word;
               if (xgmii_data !== exp_word[71:8])
               begin
                  $display("ERROR xgmii_data: expected %h, got %h", exp_word[71:8], xgmii_data);
                  fail_count++;
               end
               else
                  pass_count++;
               if (xgmii_ctrl !== exp_word[7:0])
               begin
                  $display("ERROR xgmii_ctrl: expected %h, got %h", exp_word[7:0], xgmii_ctrl);
                  fail_count++;
               end
               else
                  pass_count++;
            end
         end
         else if (!expect_cleared)
         begin
            // Outputs keep the last word between blocks
            if (xgmii_data !== held_word[71:8] || xgmii_ctrl !== held_word[7:0])
            begin
               $display("ERROR xgmii_data/xgmii_ctrl: expected %h/%h, got %h/%h",
                        held_word[71:8], held_word[7:0], xgmii_data, xgmii_ctrl);
               fail_count++;
            end
            else
               pass_count++;
         end
      end
      else
         held_word = '0;
   end

   task automatic send_block(input logic [63:0] pl, input logic [1:0] sync,
                             input logic [63:0] exp_d, input logic [7:0] exp_c);
      logic [63:0] tx;
      scramble_payload(pl, tx);
      @(posedge CLK);
      block_in    <= {tx, sync};
      block_valid <= 1'b1;
      exp_q.push_back({exp_d, exp_c});
   endtask

   task automatic send_idle();
      @(posedge CLK);
      block_in    <= {$urandom, $urandom, 2'b11};  // Junk the DUT ignores
      block_valid <= 1'b0;
   endtask

   task automatic finish_test(input string name, input int n, input int fails_before);
      send_idle();
      while (exp_q.size() != 0)
         @(posedge CLK);
      @(posedge CLK);
      $display("%s: %0d blocks, %0d failures", name, n, fail_count - fails_before);
   endtask

   task automatic run_blocks(input string name, input int n, input int lo, input int hi,
                             input bit gaps);
      logic [63:0] pl;
      logic [1:0]  sync;
      logic [63:0] exp_d;
      logic [7:0]  exp_c;
      int          fails_before;
      int          kind;
      fails_before = fail_count;
      for (int i = 0; i < n; i++)
      begin
         if (gaps && $urandom_range(1) == 1)
            send_idle();
         kind = int'($urandom_range(hi, lo));
         build_block(kind, pl, sync, exp_d, exp_c);
         send_block(pl, sync, exp_d, exp_c);
      end
      finish_test(name, n, fails_before);
   endtask

   task automatic run_bad(input int n);
      logic [63:0] pl;
      logic [1:0]  sync;
      logic [63:0] exp_d;
      logic [7:0]  exp_c;
      logic [6:0]  code;
      logic [8:0]  m;
      int          fails_before;
      int          lane;
      fails_before = fail_count;
      for (int i = 0; i < n; i++)
      begin
         case (i % 3)
            0:
            begin
               build_block(0, pl, sync, exp_d, exp_c);
               sync = ($urandom_range(1) == 1) ? 2'b00 : 2'b11;
            end
            1:
            begin
               build_block(0, pl, sync, exp_d, exp_c);
               sync = 2'b01;
               do
                  pl[7:0] = 8'($urandom);
               while (type_known(pl[7:0]));
            end
            default:
            begin
               // Types 1e and 33 both carry codes in lanes 0 to 3
               build_block(($urandom_range(1) == 1) ? 1 : 3, pl, sync, exp_d, exp_c);
               lane = int'($urandom_range(3));
               do
               begin
                  code = 7'($urandom);
                  m    = map_code(code);
               end
               while (m[8]);
               pl[8 + 7 * lane +: 7] = code;
            end
         endcase
         send_block(pl, sync, 64'hfefe_fefe_fefe_fefe, 8'hff);
      end
      finish_test("bad_blocks", n, fails_before);
   endtask

   initial
   begin
      void'($urandom(32'h91db_335e));
      reset          = 1'b1;
      block_in       = '0;
      block_valid    = 1'b0;
      tx_scr         = '0;
      expect_cleared = 1'b0;
      pass_count     = 0;
      fail_count     = 0;
      repeat (4) @(posedge CLK);
      reset          <= 1'b0;
      expect_cleared <= 1'b1;
      repeat (3) @(posedge CLK);
      expect_cleared <= 1'b0;
      $display("reset_state: %0d failures", fail_count);

      run_blocks("data_blocks", N_DATA, 0, 0, 1'b0);
      run_blocks("control_blocks", N_CTRL, 1, 1, 1'b0);
      run_blocks("start_term_blocks", N_MIXED, 2, 11, 1'b0);
      run_bad(N_BAD);
      run_blocks("gapped_stream", N_GAPPED, 0, 11, 1'b1);

      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/block_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module block_classifier
(
   input  logic [pcs_dec_pkg::SYNC_W-1:0] sync_header,
   input  pcs_dec_pkg::payload_u          payload,
   input  logic                           valid,
   output pcs_dec_pkg::lane_kind_t        lane_kind [pcs_dec_pkg::LANES],
   decode_bus_if.classifier               bus
);

   logic [2:0] term_lane;
   logic       term_hit;

   assign bus.valid = valid;

   // Terminate position from block type
   always_comb
   begin
      term_hit  = 1'b1;
      term_lane = 3'd0;
      case (payload.ctrl.block_type)
         pcs_dec_pkg::BT_TERM0: term_lane = 3'd0;
         pcs_dec_pkg::BT_TERM1: term_lane = 3'd1;
         pcs_dec_pkg::BT_TERM2: term_lane = 3'd2;
         pcs_dec_pkg::BT_TERM3: term_lane = 3'd3;
         pcs_dec_pkg::BT_TERM4: term_lane = 3'd4;
         pcs_dec_pkg::BT_TERM5: term_lane = 3'd5;
         pcs_dec_pkg::BT_TERM6: term_lane = 3'd6;
         pcs_dec_pkg::BT_TERM7: term_lane = 3'd7;
         default:               term_hit  = 1'b0;
      endcase
   end

   always_comb
   begin
      for (int k = 0; k < pcs_dec_pkg::LANES; k++)
      begin
         if (sync_header == pcs_dec_pkg::SYNC_DATA)
            lane_kind[k] = pcs_dec_pkg::LK_DATA_SAME;
         else if (sync_header != pcs_dec_pkg::SYNC_CTRL)
            lane_kind[k] = pcs_dec_pkg::LK_ERROR;  // 00 or 11
         else if (payload.ctrl.block_type == pcs_dec_pkg::BT_IDLE)
            lane_kind[k] = pcs_dec_pkg::LK_CTRL;
         else if (payload.ctrl.block_type == pcs_dec_pkg::BT_START0)
         begin
            if (k == 0)
               lane_kind[k] = pcs_dec_pkg::LK_START;
            else
               lane_kind[k] = pcs_dec_pkg::LK_DATA_SAME;
         end
         else if (payload.ctrl.block_type == pcs_dec_pkg::BT_START4)
         begin
            // Four control codes ahead of the start
            if (k < 4)
               lane_kind[k] = pcs_dec_pkg::LK_CTRL;
            else if (k == 4)
               lane_kind[k] = pcs_dec_pkg::LK_START;
            else
               lane_kind[k] = pcs_dec_pkg::LK_DATA_SAME;
         end
         else if (term_hit)
         begin
            if (k < int'(term_lane))
               lane_kind[k] = pcs_dec_pkg::LK_DATA_NEXT;
            else if (k == int'(term_lane))
               lane_kind[k] = pcs_dec_pkg::LK_TERM;
            else
               lane_kind[k] = pcs_dec_pkg::LK_CTRL;
         end
         else
            lane_kind[k] = pcs_dec_pkg::LK_ERROR;  // Unknown type
      end
   end

endmodule

`default_nettype wire

/* verilog/decode_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface decode_bus_if;
   logic                               valid;
   logic [pcs_dec_pkg::LANES-1:0][7:0] lane_data;
   logic [pcs_dec_pkg::LANES-1:0]      lane_ctrl;
   logic [pcs_dec_pkg::LANES-1:0]      lane_invalid;

   modport classifier (output valid);

   modport lane (output lane_data, lane_ctrl, lane_invalid);

   modport sink (input valid, lane_data, lane_ctrl, lane_invalid);
endinterface

`default_nettype wire

/* verilog/decoded_output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decoded_output_stage
(
   input  logic                              CLK,
   input  logic                              reset,
   decode_bus_if.sink                        bus,
   output logic                              out_valid,
   output logic [pcs_dec_pkg::PAYLOAD_W-1:0] xgmii_data,
   output logic [pcs_dec_pkg::LANES-1:0]     xgmii_ctrl
);

   logic any_invalid;

   assign any_invalid = |bus.lane_invalid;

   always_ff @(posedge CLK)
   begin
      if (reset)
      begin
         out_valid  <= 1'b0;
         xgmii_data <= '0;
         xgmii_ctrl <= '0;
      end
      else
      begin
         out_valid <= bus.valid;
         if (bus.valid)  // Data holds between blocks
         begin
            if (any_invalid)
            begin
               xgmii_data <= pcs_dec_pkg::ERROR_WORD;
               xgmii_ctrl <= pcs_dec_pkg::ERROR_CTRL;
            end
            else
            begin
               xgmii_data <= bus.lane_data;
               xgmii_ctrl <= bus.lane_ctrl;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/lane_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_decoder
#(
   parameter int LANE = 0
)
(
   input  pcs_dec_pkg::payload_u   payload,
   input  pcs_dec_pkg::lane_kind_t kind,
   decode_bus_if.lane              bus
);

   logic [7:0] code_char;
   logic       code_known;
   logic [7:0] lane_char;
   logic       lane_is_ctrl;
   logic       lane_bad;

   // Table lookup of this lane's code field
   always_comb
   begin
      code_known = 1'b0;
      code_char  = pcs_dec_pkg::XG_ERROR;
      for (int i = 0; i < pcs_dec_pkg::N_CTRL_CODES; i++)
      begin
         if (payload.ctrl.code[LANE] == pcs_dec_pkg::CTRL_CODE_7B[i])
         begin
            code_known = 1'b1;
            code_char  = pcs_dec_pkg::CTRL_CODE_XG[i];
         end
      end
   end

   always_comb
   begin
      lane_char    = pcs_dec_pkg::XG_ERROR;
      lane_is_ctrl = 1'b1;
      lane_bad     = 1'b0;
      case (kind)
         pcs_dec_pkg::LK_DATA_SAME:
         begin
            lane_char    = payload.data[LANE];
            lane_is_ctrl = 1'b0;
         end
         pcs_dec_pkg::LK_DATA_NEXT:
         begin
            // Wrap on lane 7 is never selected
            lane_char    = payload.data[(LANE + 1) % pcs_dec_pkg::LANES];
            lane_is_ctrl = 1'b0;
         end
         pcs_dec_pkg::LK_CTRL:
         begin
            lane_char = code_char;
            lane_bad  = ~code_known;
         end
         pcs_dec_pkg::LK_START: lane_char = pcs_dec_pkg::XG_START;
         pcs_dec_pkg::LK_TERM:  lane_char = pcs_dec_pkg::XG_TERM;
         default:               lane_bad  = 1'b1;
      endcase
   end

   assign bus.lane_data[LANE]    = lane_char;
   assign bus.lane_ctrl[LANE]    = lane_is_ctrl;
   assign bus.lane_invalid[LANE] = lane_bad;

endmodule

`default_nettype wire

/* verilog/pcs_dec_pkg.sv */
`default_nettype none

package pcs_dec_pkg;

   localparam int PAYLOAD_W  = 64;
   localparam int SYNC_W     = 2;
   localparam int LANES      = 8;
   localparam int SCR_HIST_W = 58;  // x^58 + x^39 + 1
   localparam int SCR_TAP    = 39;

   localparam logic [SYNC_W-1:0] SYNC_DATA = 2'b10;
   localparam logic [SYNC_W-1:0] SYNC_CTRL = 2'b01;

   // Block type field
   localparam logic [7:0] BT_IDLE   = 8'h1e;
   localparam logic [7:0] BT_START0 = 8'h78;
   localparam logic [7:0] BT_START4 = 8'h33;
   localparam logic [7:0] BT_TERM0  = 8'h87;
   localparam logic [7:0] BT_TERM1  = 8'h99;
   localparam logic [7:0] BT_TERM2  = 8'haa;
   localparam logic [7:0] BT_TERM3  = 8'hb4;
   localparam logic [7:0] BT_TERM4  = 8'hcc;
   localparam logic [7:0] BT_TERM5  = 8'hd2;
   localparam logic [7:0] BT_TERM6  = 8'he1;
   localparam logic [7:0] BT_TERM7  = 8'hff;

   // XGMII control characters
   localparam logic [7:0] XG_IDLE  = 8'h07;
   localparam logic [7:0] XG_LPI   = 8'h06;
   localparam logic [7:0] XG_START = 8'hfb;
   localparam logic [7:0] XG_TERM  = 8'hfd;
   localparam logic [7:0] XG_ERROR = 8'hfe;
   localparam logic [7:0] XG_1C    = 8'h1c;
   localparam logic [7:0] XG_3C    = 8'h3c;
   localparam logic [7:0] XG_7C    = 8'h7c;
   localparam logic [7:0] XG_BC    = 8'hbc;
   localparam logic [7:0] XG_DC    = 8'hdc;
   localparam logic [7:0] XG_F7    = 8'hf7;

   // Seven-bit codes on the line
   localparam logic [6:0] CC_IDLE  = 7'h00;
   localparam logic [6:0] CC_LPI   = 7'h06;
   localparam logic [6:0] CC_ERROR = 7'h1e;
   localparam logic [6:0] CC_1C    = 7'h2d;
   localparam logic [6:0] CC_3C    = 7'h33;
   localparam logic [6:0] CC_7C    = 7'h4b;
   localparam logic [6:0] CC_BC    = 7'h55;
   localparam logic [6:0] CC_DC    = 7'h66;
   localparam logic [6:0] CC_F7    = 7'h78;

   localparam int N_CTRL_CODES = 9;

   // Paired by index
   localparam logic [N_CTRL_CODES-1:0][6:0] CTRL_CODE_7B =
      {CC_IDLE, CC_LPI, CC_ERROR, CC_1C, CC_3C, CC_7C, CC_BC, CC_DC, CC_F7};
   localparam logic [N_CTRL_CODES-1:0][7:0] CTRL_CODE_XG =
      {XG_IDLE, XG_LPI, XG_ERROR, XG_1C, XG_3C, XG_7C, XG_BC, XG_DC, XG_F7};

   localparam logic [PAYLOAD_W-1:0] ERROR_WORD = 64'hfefe_fefe_fefe_fefe;
   localparam logic [LANES-1:0]     ERROR_CTRL = 8'hff;

   typedef enum logic [2:0] {
      LK_DATA_SAME,  // payload byte k
      LK_DATA_NEXT,  // payload byte k+1, terminate blocks
      LK_CTRL,
      LK_START,
      LK_TERM,
      LK_ERROR
   } lane_kind_t;

   typedef union packed {
      logic [LANES-1:0][7:0] data;
      struct packed {
         logic [LANES-1:0][6:0] code;  // code k at bit 8+7k
         logic [7:0]            block_type;
      } ctrl;
   } payload_u;

endpackage

`default_nettype wire

/* verilog/pcs_rx_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_decoder
(
   input  logic                                                  CLK,
   input  logic                                                  reset,
   input  logic [pcs_dec_pkg::SYNC_W+pcs_dec_pkg::PAYLOAD_W-1:0] block_in,
   input  logic                                                  block_valid,
   output logic                                                  out_valid,
   output logic [pcs_dec_pkg::PAYLOAD_W-1:0]                     xgmii_data,
   output logic [pcs_dec_pkg::LANES-1:0]                         xgmii_ctrl
);

   pcs_dec_pkg::payload_u          payload;
   logic [pcs_dec_pkg::SYNC_W-1:0] sync_header;
   logic                           desc_valid;
   pcs_dec_pkg::lane_kind_t        lane_kind [pcs_dec_pkg::LANES];

   decode_bus_if bus_i ();

   rx_descrambler descrambler_i
   (
      .CLK         (CLK),
      .reset       (reset),
      .block_in    (block_in),
      .block_valid (block_valid),
      .payload     (payload),
      .sync_header (sync_header),
      .valid       (desc_valid)
   );

   block_classifier classifier_i
   (
      .sync_header (sync_header),
      .payload     (payload),
      .valid       (desc_valid),
      .lane_kind   (lane_kind),
      .bus         (bus_i)
   );

   for (genvar k = 0; k < pcs_dec_pkg::LANES; k++)
   begin : g_lane
      lane_decoder #(.LANE(k)) lane_i
      (
         .payload (payload),
         .kind    (lane_kind[k]),
         .bus     (bus_i)
      );
   end

   decoded_output_stage out_stage_i
   (
      .CLK        (CLK),
      .reset      (reset),
      .bus        (bus_i),
      .out_valid  (out_valid),
      .xgmii_data (xgmii_data),
      .xgmii_ctrl (xgmii_ctrl)
   );

endmodule

`default_nettype wire

/* verilog/rx_descrambler.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_descrambler
(
   input  logic                                                  CLK,
   input  logic                                                  reset,
   input  logic [pcs_dec_pkg::SYNC_W+pcs_dec_pkg::PAYLOAD_W-1:0] block_in,
   input  logic                                                  block_valid,
   output pcs_dec_pkg::payload_u                                 payload,
   output logic [pcs_dec_pkg::SYNC_W-1:0]                        sync_header,
   output logic                                                  valid
);

   logic [pcs_dec_pkg::PAYLOAD_W-1:0]                        scrambled;
   logic [pcs_dec_pkg::SCR_HIST_W-1:0]                       history;
   logic [pcs_dec_pkg::SCR_HIST_W+pcs_dec_pkg::PAYLOAD_W-1:0] stream;

   assign sync_header = block_in[pcs_dec_pkg::SYNC_W-1:0];
   assign scrambled   = block_in[pcs_dec_pkg::SYNC_W +: pcs_dec_pkg::PAYLOAD_W];
   assign valid       = block_valid;

   // Oldest received bit at 0, payload bit i at SCR_HIST_W+i
   assign stream = {scrambled, history};

   assign payload = scrambled
                  ^ stream[pcs_dec_pkg::SCR_HIST_W-pcs_dec_pkg::SCR_TAP +: pcs_dec_pkg::PAYLOAD_W]
                  ^ stream[0 +: pcs_dec_pkg::PAYLOAD_W];

   always_ff @(posedge CLK)
   begin
      if (reset)
         history <= '0;
      else if (block_valid)  // Holds across idle cycles
         history <= scrambled[pcs_dec_pkg::PAYLOAD_W-1 -: pcs_dec_pkg::SCR_HIST_W];
   end

endmodule

`default_nettype wire
